//--- Makefile
# Verilator simulation of the audio tone controller

VERILATOR ?= verilator
TOP       ?= tb_audio_controller
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= All tests passed

.PHONY: sim clean

# Build, run, then decide pass or fail from the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- all.f
+incdir+design
design/audio_reg_pkg.sv
design/audio_dsp_pkg.sv
design/audio_regs.sv
design/tone_voice.sv
design/i2s_clock_gen.sv
design/voice_mixer.sv
design/i2s_transmitter.sv
design/audio_controller.sv
verification/tb_audio_controller.sv

//--- design/audio_controller.sv
module audio_controller
    import audio_reg_pkg::*, audio_dsp_pkg::*;
(
    input  logic       clk_audio,
    input  logic       reset,
    // Wishbone classic slave
    input  logic       wb_cyc,
    input  logic       wb_stb,
    input  logic       wb_we,
    input  logic [3:0] wb_adr,
    input  reg_word_t  wb_dat_w,
    output logic       wb_ack,
    output reg_word_t  wb_dat_r,
    // I2S to the DAC
    output logic       audio_mclk,
    output logic       audio_lrck,
    output logic       audio_sclk,
    output logic       audio_sdin
);

    reg_word_t saw_freq, saw_dur, sq_freq, sq_dur;
    logic      saw_start, sq_start;
    logic      saw_playing, sq_playing;
    sample_t   saw_sample, sq_sample, mix_sample;
    logic      sclk_fall, frame_tick, chan_edge;

    assign audio_mclk = clk_audio;      // MCLK straight from the clock

    // ==============================
    // Register stage
    // ==============================
    audio_regs regs_i (
        .clk_audio, .reset,
        .wb_cyc, .wb_stb, .wb_we,
        .wb_adr    (reg_offset_t'(wb_adr)),     // Holes decode to default
        .wb_dat_w, .wb_ack, .wb_dat_r,
        .saw_playing, .sq_playing,
        .saw_freq, .saw_dur, .sq_freq, .sq_dur,
        .saw_start, .sq_start
    );

    // Voice stage
    tone_voice #(.SHAPE(SHAPE_SAW)) saw_voice_i (
        .clk_audio, .reset, .start(saw_start), .frame_tick,
        .freq(saw_freq), .dur(saw_dur), .playing(saw_playing), .sample(saw_sample)
    );

    tone_voice #(.SHAPE(SHAPE_SQUARE)) sq_voice_i (
        .clk_audio, .reset, .start(sq_start), .frame_tick,
        .freq(sq_freq), .dur(sq_dur), .playing(sq_playing), .sample(sq_sample)
    );

    // Mixer and serializer stages
    voice_mixer mixer_i (
        .clk_audio, .reset, .frame_tick, .saw_playing, .sq_playing,
        .saw_sample, .sq_sample, .mix_sample
    );

    i2s_clock_gen clock_gen_i (
        .clk_audio, .reset, .sclk(audio_sclk), .lrck(audio_lrck),
        .sclk_fall, .frame_tick, .chan_edge
    );

    i2s_transmitter tx_i (
        .clk_audio, .reset, .sclk_fall, .chan_edge, .mix_sample, .sdin(audio_sdin)
    );

endmodule

//--- design/audio_dsp_pkg.sv
`include "audio_params.svh"

package audio_dsp_pkg;

    // ==============================
    // Signal path types
    // ==============================

    // Two's complement audio sample
    typedef logic signed [`AUDIO_DATA_W-1:0] sample_t;

    // Phase word, read two ways by the voices
    typedef union packed {
        struct packed {
            logic [`AUDIO_PHASE_W/2-1:0] upper;     // Saw level before offset
            logic [`AUDIO_PHASE_W/2-1:0] frac;      // Sub-step precision
        } saw;
        struct packed {
            logic                        sign;      // Selects the square level
            logic [`AUDIO_PHASE_W-2:0]   rest;      // Remaining phase bits
        } sq;
    } phase_word_t;

    // Waveform decode of a voice
    typedef enum logic {
        SHAPE_SAW,                      // Top phase bits minus half scale
        SHAPE_SQUARE                    // Phase MSB picks one of two levels
    } wave_shape_t;

endpackage

//--- design/audio_params.svh
`ifndef AUDIO_PARAMS_SVH
`define AUDIO_PARAMS_SVH

// ==============================
// Data path widths
// ==============================
`define AUDIO_DATA_W        16          // Bus word, register and sample width
`define AUDIO_PHASE_W       32          // Phase accumulator width

// ==============================
// Timing divisors
// ==============================
`define AUDIO_TICKS_PER_MS  24576       // clk_audio cycles in one millisecond
`define AUDIO_SCLK_HALF     4           // clk_audio cycles per SCLK half period
`define AUDIO_SCLK_PER_CHAN 32          // SCLK periods per LRCK half
`define AUDIO_PHASE_STEP    89478       // About 2^32 / 48000, phase step per Hz

// Square levels, symmetric around zero
`define AUDIO_SQ_HIGH       16'h3FFF
`define AUDIO_SQ_LOW        16'hC000

// Register reset values, saw values double as the self-test tone
`define AUDIO_RST_SAW_FREQ  16'd3000
`define AUDIO_RST_SAW_DUR   16'd500
`define AUDIO_RST_SQ_FREQ   16'd440
`define AUDIO_RST_SQ_DUR    16'd0
`define AUDIO_READ_IDLE     16'hFFFF    // Returned for unmapped offsets

`endif

//--- design/audio_reg_pkg.sv
`include "audio_params.svh"

package audio_reg_pkg;

    // ==============================
    // Register map
    // ==============================

    // Word offsets on wb_adr
    typedef enum logic [3:0] {
        SAW_FREQ = 4'h0,                // Saw frequency in Hz
        SAW_DUR  = 4'h1,                // Saw duration in ms, write starts the voice
        SQ_FREQ  = 4'h2,                // Square frequency in Hz
        SQ_DUR   = 4'h3,                // Square duration in ms, write starts the voice
        STATUS   = 4'h4                 // Read only, bit 0 saw playing, bit 1 square playing
    } reg_offset_t;

    // One register word, same width as the bus
    typedef logic [`AUDIO_DATA_W-1:0] reg_word_t;

    // Status bit positions
    localparam int STAT_SAW_BIT = 0;
    localparam int STAT_SQ_BIT  = 1;

endpackage

//--- design/audio_regs.sv
`include "audio_params.svh"

module audio_regs
    import audio_reg_pkg::*;
(
    input  logic        clk_audio,
    input  logic        reset,
    // Wishbone classic slave
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_we,
    input  reg_offset_t wb_adr,
    input  reg_word_t   wb_dat_w,
    output logic        wb_ack,
    output reg_word_t   wb_dat_r,
    // Voice side
    input  logic        saw_playing,
    input  logic        sq_playing,
    output reg_word_t   saw_freq,
    output reg_word_t   saw_dur,
    output reg_word_t   sq_freq,
    output reg_word_t   sq_dur,
    output logic        saw_start,
    output logic        sq_start
);

    logic      req;                     // First cycle of a bus request
    logic      wr;                      // Write request
    logic      post_pending;            // Self-test start still owed
    reg_word_t status;

    assign req = wb_cyc && wb_stb && !wb_ack;   // ack blocks a second hit
    assign wr  = req && wb_we;

    always_comb begin
        status = '0;
        status[STAT_SAW_BIT] = saw_playing;
        status[STAT_SQ_BIT]  = sq_playing;
    end

    // ==============================
    // Registers, ack and start pulses
    // ==============================
    always_ff @(posedge clk_audio) begin
        if (reset) begin
            wb_ack       <= 1'b0;
            saw_freq     <= `AUDIO_RST_SAW_FREQ;
            saw_dur      <= `AUDIO_RST_SAW_DUR;
            sq_freq      <= `AUDIO_RST_SQ_FREQ;
            sq_dur       <= `AUDIO_RST_SQ_DUR;
            saw_start    <= 1'b0;
            sq_start     <= 1'b0;
            post_pending <= 1'b1;                   // Arm the self-test tone
        end else begin
            wb_ack       <= req;                    // Single cycle, no wait state
            post_pending <= 1'b0;
            saw_start    <= post_pending || (wr && wb_adr == SAW_DUR);
            sq_start     <= wr && wb_adr == SQ_DUR;
            if (wr) begin
                case (wb_adr)
                    SAW_FREQ: saw_freq <= wb_dat_w;
                    SAW_DUR:  saw_dur  <= wb_dat_w;
                    SQ_FREQ:  sq_freq  <= wb_dat_w;
                    SQ_DUR:   sq_dur   <= wb_dat_w;
                    default: ;                      // STATUS and holes drop the data
                endcase
            end
        end
    end

    // Read data, captured with ack
    always_ff @(posedge clk_audio) begin
        if (req) begin
            case (wb_adr)
                SAW_FREQ: wb_dat_r <= saw_freq;
                SAW_DUR:  wb_dat_r <= saw_dur;
                SQ_FREQ:  wb_dat_r <= sq_freq;
                SQ_DUR:   wb_dat_r <= sq_dur;
                STATUS:   wb_dat_r <= status;
                default:  wb_dat_r <= `AUDIO_READ_IDLE;
            endcase
        end
    end

    // Every ack answers a request seen one cycle earlier
    a_ack_follows_req: assert property (
        @(posedge clk_audio) disable iff (reset)
        wb_ack |-> $past(wb_cyc && wb_stb)
    );

endmodule

//--- design/i2s_clock_gen.sv
`include "audio_params.svh"

module i2s_clock_gen (
    input  logic clk_audio,
    input  logic reset,
    output logic sclk,
    output logic lrck,
    output logic sclk_fall,             // First cycle with sclk low
    output logic frame_tick,            // First cycle with lrck high
    output logic chan_edge              // First cycle after any lrck change
);

    localparam int HALF_W = $clog2(`AUDIO_SCLK_HALF);
    localparam int CHAN_W = $clog2(`AUDIO_SCLK_PER_CHAN);

    logic [HALF_W-1:0] half_cnt;        // clk_audio cycles in this SCLK half
    logic [CHAN_W-1:0] chan_cnt;        // SCLK periods in this channel

    always_ff @(posedge clk_audio) begin
        if (reset) begin
            half_cnt   <= '0;
            chan_cnt   <= '0;
            sclk       <= 1'b0;
            lrck       <= 1'b0;
            sclk_fall  <= 1'b0;
            frame_tick <= 1'b0;
            chan_edge  <= 1'b0;
        end else begin
            sclk_fall  <= 1'b0;                     // Strobes default low
            frame_tick <= 1'b0;
            chan_edge  <= 1'b0;
            if (half_cnt == HALF_W'(`AUDIO_SCLK_HALF - 1)) begin
                half_cnt <= '0;
                sclk     <= ~sclk;
                if (sclk) begin
                    sclk_fall <= 1'b1;              // High to low
                end else if (chan_cnt == CHAN_W'(`AUDIO_SCLK_PER_CHAN - 1)) begin
                    chan_cnt   <= '0;               // LRCK moves with SCLK rising
                    lrck       <= ~lrck;
                    chan_edge  <= 1'b1;
                    frame_tick <= ~lrck;            // Rising LRCK only
                end else begin
                    chan_cnt <= chan_cnt + 1'b1;
                end
            end else begin
                half_cnt <= half_cnt + 1'b1;
            end
        end
    end

endmodule

//--- design/i2s_transmitter.sv
module i2s_transmitter
    import audio_dsp_pkg::*;
(
    input  logic    clk_audio,
    input  logic    reset,
    input  logic    sclk_fall,
    input  logic    chan_edge,
    input  sample_t mix_sample,
    output logic    sdin
);

    localparam int DATA_W = $bits(sample_t);
    localparam int CNT_W  = $clog2(DATA_W + 1);

    typedef enum logic [1:0] {
        TX_WAIT,                        // Idle until the next channel starts
        TX_DELAY,                       // I2S one-bit delay slot
        TX_SHIFT                        // Data bits, MSB first
    } tx_state_t;

    tx_state_t          state;
    logic [DATA_W-1:0]  shift_reg;
    logic [CNT_W-1:0]   bit_cnt;        // Bits already sent

    // ==============================
    // Serializer
    // ==============================
    always_ff @(posedge clk_audio) begin
        if (reset) begin
            state   <= TX_WAIT;
            bit_cnt <= '0;
            sdin    <= 1'b0;
        end else begin
            case (state)
                TX_WAIT: begin
                    if (chan_edge) begin
                        shift_reg <= mix_sample;    // Same word on both channels
                        bit_cnt   <= '0;
                        state     <= TX_DELAY;
                    end
                end
                TX_DELAY: begin
                    if (sclk_fall)
                        state <= TX_SHIFT;          // First falling edge skipped
                end
                TX_SHIFT: begin
                    if (sclk_fall) begin
                        if (bit_cnt < CNT_W'(DATA_W)) begin
                            sdin      <= shift_reg[DATA_W-1];
                            shift_reg <= {shift_reg[DATA_W-2:0], 1'b0};
                            bit_cnt   <= bit_cnt + 1'b1;
                        end else begin
                            sdin  <= 1'b0;          // Pad rest of channel
                            state <= TX_WAIT;
                        end
                    end
                end
                default: state <= TX_WAIT;
            endcase
        end
    end

    // Line stays quiet between words
    a_quiet_in_wait: assert property (
        @(posedge clk_audio) disable iff (reset)
        state == TX_WAIT |-> !sdin
    );

endmodule

//--- design/tone_voice.sv
`include "audio_params.svh"

module tone_voice
    import audio_reg_pkg::*, audio_dsp_pkg::*;
#(
    parameter wave_shape_t SHAPE = SHAPE_SAW
) (
    input  logic      clk_audio,
    input  logic      reset,
    input  logic      start,            // One cycle, from a duration write
    input  logic      frame_tick,       // Once per stereo frame
    input  reg_word_t freq,             // Hz
    input  reg_word_t dur,              // ms
    output logic      playing,
    output sample_t   sample
);

    localparam int TICKS = `AUDIO_TICKS_PER_MS;
    localparam int PRE_W = $clog2(TICKS + 1);
    localparam logic [`AUDIO_PHASE_W-1:0] STEP = `AUDIO_PHASE_STEP;
    localparam reg_word_t HALF_SCALE = {1'b1, {(`AUDIO_DATA_W-1){1'b0}}};

    logic [PRE_W-1:0]          prescale;    // Cycles into the current ms
    reg_word_t                 remaining;   // Whole ms left
    logic [`AUDIO_PHASE_W-1:0] phase_inc;
    phase_word_t               phase;
    sample_t                   wave;        // Decoded level of the current phase

    // ==============================
    // Duration timer
    // ==============================
    always_ff @(posedge clk_audio) begin
        if (reset) begin
            playing   <= 1'b0;
            remaining <= '0;
            prescale  <= '0;
        end else if (start && dur != '0) begin      // Zero duration never starts
            playing   <= 1'b1;
            remaining <= dur;
            prescale  <= '0;                        // Restart the ms grid
        end else if (playing) begin
            if (prescale == PRE_W'(TICKS - 1)) begin
                prescale  <= '0;
                remaining <= remaining - 1'b1;
                if (remaining == reg_word_t'(1))
                    playing <= 1'b0;                // Last ms done
            end else begin
                prescale <= prescale + 1'b1;
            end
        end
    end

    // Multiplier kept off the accumulator path
    always_ff @(posedge clk_audio) begin
        phase_inc <= freq * STEP;                   // Wraps mod 2^32 for high freq
    end

    // Sample from the phase before it advances
    always_ff @(posedge clk_audio) begin
        if (reset || !playing) begin
            phase  <= '0;
            sample <= '0;
        end else if (frame_tick) begin
            sample <= wave;
            phase  <= phase + phase_inc;
        end
    end

    // Waveform decode
    always_comb begin
        if (SHAPE == SHAPE_SAW)
            wave = sample_t'(phase.saw.upper - HALF_SCALE);     // Offset binary to signed
        else
            wave = phase.sq.sign ? sample_t'(`AUDIO_SQ_HIGH) : sample_t'(`AUDIO_SQ_LOW);
    end

    // Countdown never sits at zero while the voice plays
    a_playing_has_time: assert property (
        @(posedge clk_audio) disable iff (reset)
        playing |-> remaining != '0
    );

endmodule

//--- design/voice_mixer.sv
module voice_mixer
    import audio_dsp_pkg::*;
(
    input  logic    clk_audio,
    input  logic    reset,
    input  logic    frame_tick,
    input  logic    saw_playing,
    input  logic    sq_playing,
    input  sample_t saw_sample,
    input  sample_t sq_sample,
    output sample_t mix_sample
);

    logic signed [$bits(sample_t):0] sum;   // One guard bit for the average

    assign sum = saw_sample + sq_sample;    // Sign extended by context

    // ==============================
    // Mix, held between frames
    // ==============================
    always_ff @(posedge clk_audio) begin
        if (reset) begin
            mix_sample <= '0;
        end else if (frame_tick) begin
            case ({saw_playing, sq_playing})
                2'b11:   mix_sample <= sample_t'(sum >>> 1);    // Average keeps range
                2'b10:   mix_sample <= saw_sample;
                2'b01:   mix_sample <= sq_sample;
                default: mix_sample <= '0;                      // Silence
            endcase
        end
    end

endmodule

//--- verification/tb_audio_controller.sv
`include "audio_params.svh"

module tb_audio_controller
    import audio_reg_pkg::*;
();

    localparam int DRIVE_DLY   = 10;            // Input skew after the rising edge
    localparam int ACK_LIMIT   = 16;            // Cycles allowed for wb_ack
    localparam int SKIP_WORDS  = 6;             // Words still in flight after a mode change
    localparam int CHECK_WORDS = 10;
    localparam int TICKS       = `AUDIO_TICKS_PER_MS;
    localparam int FRAME_CYC   = 4 * `AUDIO_SCLK_PER_CHAN * `AUDIO_SCLK_HALF;
    localparam int PLAY_MS     = (20 * FRAME_CYC) / TICKS + 1;     // At least 20 frames
    localparam int POLL_SLACK  = 4;             // One status poll plus capture latency
    localparam longint PHASE_PER_HZ = 89478;

    // Word check modes
    localparam int MODE_OFF    = 0;
    localparam int MODE_SILENT = 1;
    localparam int MODE_SQUARE = 2;
    localparam int MODE_MIX    = 3;
    localparam int MODE_SAW    = 4;

    logic        clk_audio;
    logic        reset;
    logic        wb_cyc, wb_stb, wb_we;
    logic [3:0]  wb_adr;
    logic [15:0] wb_dat_w;
    logic        wb_ack;
    logic [15:0] wb_dat_r;
    logic        audio_mclk, audio_lrck, audio_sclk, audio_sdin;

    int          check_mode;                    // Set by the stimulus
    int          seen_mode;
    int          words_seen;                    // Words received in the current mode
    int          bit_idx;                       // 0 delay slot, 1..16 data, 17 idle
    int unsigned cycle_cnt = 0;
    logic        sclk_q, lrck_q;
    logic        chan_left, rx_left, word_done;
    logic [15:0] shift_word, rx_word, left_word, prev_left;
    logic [15:0] saw_step;                      // Expected saw phase step per frame

    audio_controller dut_i (
        .clk_audio  (clk_audio),
        .reset      (reset),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_dat_w   (wb_dat_w),
        .wb_ack     (wb_ack),
        .wb_dat_r   (wb_dat_r),
        .audio_mclk (audio_mclk),
        .audio_lrck (audio_lrck),
        .audio_sclk (audio_sclk),
        .audio_sdin (audio_sdin)
    );

    initial clk_audio = 1'b0;
    always #50 clk_audio = ~clk_audio;

    always @(posedge clk_audio) cycle_cnt <= cycle_cnt + 1;    // Time base for timing checks

    // ==============================
    // I2S deserializer
    // ==============================
    always @(negedge clk_audio) begin              // Away from every DUT edge
        word_done <= 1'b0;
        if (reset) begin
            sclk_q     <= 1'b0;
            lrck_q     <= 1'b0;
            bit_idx    <= 17;
            words_seen <= 0;
            seen_mode  <= MODE_OFF;
            chan_left  <= 1'b1;
            rx_left    <= 1'b0;
            rx_word    <= '0;
            left_word  <= '0;
            prev_left  <= '0;
            shift_word <= '0;
        end else begin
            sclk_q <= audio_sclk;
            lrck_q <= audio_lrck;
            if (audio_lrck != lrck_q) begin
                bit_idx   <= 0;                     // New channel starts
                chan_left <= !audio_lrck;           // LRCK low is left
            end else if (audio_sclk && !sclk_q && bit_idx <= 16) begin
                if (bit_idx > 0)
                    shift_word <= {shift_word[14:0], audio_sdin};
                if (bit_idx == 16) begin            // LSB in, word done
                    rx_word    <= {shift_word[14:0], audio_sdin};
                    rx_left    <= chan_left;
                    word_done  <= 1'b1;
                    words_seen <= words_seen + 1;
                    if (chan_left) begin
                        prev_left <= left_word;
                        left_word <= {shift_word[14:0], audio_sdin};
                    end
                end
                bit_idx <= bit_idx + 1;
            end
            if (check_mode != seen_mode) begin      // Count restarts with the mode
                seen_mode  <= check_mode;
                words_seen <= 0;
            end
        end
    end

    // ==============================
    // Failure reporting
    // ==============================
    task automatic fail_run();
        $display("Some tests failed");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic value_error(input string sig, input string expected, input logic [15:0] actual);
        $display("ERROR at %0t: %s expected %s, got %h", $time, sig, expected, actual);
        fail_run();
    endtask

    function automatic logic step_matches(input logic [15:0] prev, input logic [15:0] cur,
                                          input logic [15:0] step);
        logic [15:0] diff;
        diff = cur - prev;                          // Modulo 2^16
        return (diff == step) || (diff == step + 16'd1);   // Carry out of the fraction
    endfunction

    // MCLK follows the audio clock in both phases
    always @(clk_audio) begin
        #DRIVE_DLY;
        assert (audio_mclk === clk_audio)
            else value_error("audio_mclk", $sformatf("%b", clk_audio), 16'(audio_mclk));
    end

    // Word checks, each armed by check_mode
    a_silent_words: assert property (@(posedge clk_audio) disable iff (reset)
        word_done && check_mode == MODE_SILENT && words_seen > SKIP_WORDS |-> rx_word == 16'h0000)
        else value_error("audio_sdin word", "0000", rx_word);

    a_square_levels: assert property (@(posedge clk_audio) disable iff (reset)
        word_done && check_mode == MODE_SQUARE && words_seen > SKIP_WORDS
        |-> rx_word == 16'h3FFF || rx_word == 16'hC000)
        else value_error("audio_sdin word", "3fff or c000", rx_word);

    a_square_pairs: assert property (@(posedge clk_audio) disable iff (reset)
        word_done && check_mode == MODE_SQUARE && words_seen > SKIP_WORDS + 1 && !rx_left
        |-> rx_word == left_word)
        else value_error("audio_sdin right word", $sformatf("%h", left_word), rx_word);

    a_mix_levels: assert property (@(posedge clk_audio) disable iff (reset)
        word_done && check_mode == MODE_MIX && words_seen > SKIP_WORDS
        |-> rx_word == 16'hDFFF || rx_word == 16'hA000)
        else value_error("audio_sdin word", "dfff or a000", rx_word);

    a_saw_steps: assert property (@(posedge clk_audio) disable iff (reset)
        word_done && check_mode == MODE_SAW && words_seen > SKIP_WORDS + 2 && rx_left
        |-> step_matches(prev_left, rx_word, saw_step))
        else value_error("audio_sdin left word",
                         $sformatf("%h plus %h or one more", prev_left, saw_step), rx_word);

    // ==============================
    // Wishbone master and waits
    // ==============================
    task automatic wb_access(input logic we, input logic [3:0] adr, input logic [15:0] wdata,
                             output logic [15:0] rdata);
        int   waited;
        logic got_ack;
        got_ack  = 1'b0;
        rdata    = '0;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = wdata;
        for (waited = 0; waited < ACK_LIMIT && !got_ack; waited++) begin
            @(posedge clk_audio);
            #DRIVE_DLY;
            got_ack = wb_ack;
        end
        if (!got_ack) begin
            $display("Wishbone access to offset %0d got no ack within %0d cycles", adr, ACK_LIMIT);
            fail_run();
        end else begin
            rdata  = wb_dat_r;                      // Valid while ack is high
            wb_cyc = 1'b0;
            wb_stb = 1'b0;
            wb_we  = 1'b0;
        end
    endtask

    task automatic wb_write(input logic [3:0] adr, input logic [15:0] data);
        logic [15:0] unused;
        wb_access(1'b1, adr, data, unused);
    endtask

    task automatic wb_read(input logic [3:0] adr, output logic [15:0] data);
        wb_access(1'b0, adr, '0, data);
    endtask

    task automatic check_reg(input logic [3:0] adr, input logic [15:0] expected, input string sig);
        logic [15:0] got;
        wb_read(adr, got);
        assert (got == expected)
            else value_error(sig, $sformatf("%h", expected), got);
    endtask

    task automatic set_mode(input int mode);
        check_mode = mode;
        @(posedge clk_audio);                       // Lets the word count restart
        #DRIVE_DLY;
    endtask

    task automatic wait_words(input int count);
        int limit;
        int waited;
        limit = (count + 4) * FRAME_CYC / 2;
        for (waited = 0; waited < limit && words_seen < count; waited++) begin
            @(posedge clk_audio);
            #DRIVE_DLY;
        end
        if (words_seen < count) begin
            $display("Only %0d of %0d I2S words arrived in time", words_seen, count);
            fail_run();
        end
    endtask

    task automatic wait_status(input logic [15:0] target, input int unsigned limit);
        int unsigned t0;
        logic [15:0] stat;
        t0   = cycle_cnt;
        stat = ~target;
        while (stat != target && cycle_cnt - t0 < limit)
            wb_read(STATUS, stat);                  // Poll until the voices settle
        if (stat != target) begin
            $display("Status never reached %h within %0d cycles", target, limit);
            fail_run();
        end
    endtask

    // ==============================
    // Stimulus
    // ==============================
    initial begin
        logic [15:0] rnd;
        logic [15:0] dur;
        int unsigned freq;
        int unsigned t_start;
        int unsigned elapsed;
        void'($urandom(47));
        reset      = 1'b1;
        wb_cyc     = 1'b0;
        wb_stb     = 1'b0;
        wb_we      = 1'b0;
        wb_adr     = '0;
        wb_dat_w   = '0;
        check_mode = MODE_OFF;
        saw_step   = '0;
        repeat (16) @(posedge clk_audio);
        #DRIVE_DLY;
        reset = 1'b0;

        // Reset values and the self-test tone
        check_reg(SAW_FREQ, 16'd3000, "saw_freq");
        check_reg(SAW_DUR, 16'd500, "saw_dur");
        check_reg(SQ_FREQ, 16'd440, "sq_freq");
        check_reg(SQ_DUR, 16'd0, "sq_dur");
        check_reg(STATUS, 16'h0001, "status");
        check_reg(4'd9, 16'hFFFF, "wb_dat_r at offset 9");

        // Random readback, STATUS is read only
        rnd = 16'($urandom);
        wb_write(SAW_FREQ, rnd);
        check_reg(SAW_FREQ, rnd, "saw_freq");
        rnd = 16'($urandom);
        wb_write(SQ_FREQ, rnd);
        check_reg(SQ_FREQ, rnd, "sq_freq");
        wb_write(STATUS, 16'($urandom));
        check_reg(STATUS, 16'h0001, "status");

        // Duration write restarts the saw, then it must stop on time
        dur = 16'($urandom_range(2, 1));
        wb_write(SAW_DUR, dur);
        t_start = cycle_cnt;
        check_reg(STATUS, 16'h0001, "status");
        wait_status(16'h0000, dur * TICKS + 64);
        elapsed = cycle_cnt - t_start;
        assert (elapsed > dur * TICKS && elapsed <= dur * TICKS + POLL_SLACK)
            else begin
                $display("ERROR at %0t: saw_playing length expected %0d to %0d cycles, got %0d",
                         $time, dur * TICKS + 1, dur * TICKS + POLL_SLACK, elapsed);
                fail_run();
            end

        // Zero duration is ignored, output stays silent
        wb_write(SQ_DUR, 16'd0);
        check_reg(STATUS, 16'h0000, "status");
        set_mode(MODE_SILENT);
        wait_words(SKIP_WORDS + CHECK_WORDS);

        // Square voice alone
        wb_write(SQ_FREQ, 16'($urandom_range(4000, 200)));
        wb_write(SQ_DUR, 16'(PLAY_MS));
        set_mode(MODE_SQUARE);
        wait_words(SKIP_WORDS + CHECK_WORDS);
        set_mode(MODE_OFF);
        wait_status(16'h0000, PLAY_MS * TICKS + 1024);

        // Both voices, saw parked at its lowest level
        wb_write(SAW_FREQ, 16'd0);
        wb_write(SQ_DUR, 16'(PLAY_MS));
        wb_write(SAW_DUR, 16'(PLAY_MS));
        set_mode(MODE_MIX);
        wait_words(SKIP_WORDS + CHECK_WORDS);
        set_mode(MODE_OFF);
        wait_status(16'h0000, PLAY_MS * TICKS + 1024);

        // Saw voice alone, frame to frame step
        freq     = $urandom_range(3000, 100);
        saw_step = 16'((longint'(freq) * PHASE_PER_HZ) >> 16);
        wb_write(SAW_FREQ, 16'(freq));
        wb_write(SAW_DUR, 16'(PLAY_MS));
        set_mode(MODE_SAW);
        wait_words(SKIP_WORDS + CHECK_WORDS);
        set_mode(MODE_OFF);

        $display("All tests passed");
        $finish;
    end

endmodule
